//--- verilog.f
flight_pkg.sv
wb_pkg.sv
mixer_if.sv
wb_rate_regs.sv
mix_sign_distributor.sv
motor_rate_channel.sv
motor_output_bank.sv
quad_mixer_top.sv
tb_quad_mixer.sv

//--- tb_quad_mixer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for quad_mixer_top with default parameters
// Concurrent checks compare against a reference model of the X-frame mix
// Bus accesses start 1 ns after a rising edge, two cycles each
// Random commands come from an xorshift generator with a fixed seed
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_quad_mixer import flight_pkg::*, wb_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_ACCESS = 229;                 // Bus accesses issued below
  localparam int TIMEOUT  = 20 * N_ACCESS + 200;
  localparam int YS [4] = '{-1, 1, 1, -1};       // X-frame yaw signs, motor 1 first
  localparam int RS [4] = '{1, -1, 1, -1};
  localparam int PS [4] = '{-1, -1, 1, 1};

  logic sys_clk, rst_n, wb_cyc, wb_stb, wb_we, wb_ack, mix_done;
  wb_adr_t     wb_adr;
  wb_dat_t     wb_dat_w, wb_dat_r;
  motor_rate_t motor_1_rate, motor_2_rate, motor_3_rate, motor_4_rate;
  reject_cnt_t reject_count;

  logic signed [15:0] sp [4];      // Model setpoints: yaw, roll, pitch, throttle
  motor_rate_t last_good [4];
  reject_cnt_t rej;                // Model reject count
  logic [31:0] exp_pack [64];      // Expected {m4, m3, m2, m1} per pass
  reject_cnt_t exp_rej [64];
  int          commit_idx = 0;
  int          done_idx = 0;
  int          err_val = 0;
  int          err_tim = 0;
  int          cycles = 0;
  logic [31:0] rng = 32'h7a5be664;
  logic        started = 1'b0;     // Low until the first bus access
  logic        rd_check = 1'b0;
  wb_dat_t     rd_exp = '0;
  logic        commit_req, new_req;

  quad_mixer_top DUT (.*);

  assign new_req    = wb_cyc && wb_stb && !wb_ack;  // First sample of an access
  assign commit_req = new_req && wb_we && (wb_adr == REG_COMMIT);

  initial begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;
  end

  always @(posedge sys_clk) begin
    cycles++;
    if (mix_done) done_idx <= done_idx + 1;  // Next expected pass
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, an ack or done never arrived", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  task automatic rand_in(input int lo, input int hi, output logic [15:0] v);
    rng = xorshift(rng);
    v = 16'(lo + int'(rng % (hi - lo + 1)));  // Q12.4 raw value
  endtask

  // Mixing rule applied to the current setpoints, one pass
  task automatic model_commit();
    int   s;
    int   r;
    logic any_rej;
    any_rej = 1'b0;
    for (int m = 0; m < 4; m++) begin
      s = int'(DEF_MOTOR_BIAS) + int'(sp[3]) + ((YS[m] * int'(sp[0])) >>> 1)
        + ((RS[m] * int'(sp[1])) >>> 1) + ((PS[m] * int'(sp[2])) >>> 1);
      r = (s + 8) >>> 4;  // Round half up to integer
      if (r >= int'(DEF_MOTOR_MIN) && r <= int'(DEF_MOTOR_MAX)) last_good[m] = r[7:0];
      else any_rej = 1'b1;  // Motor keeps its last good rate
    end
    if (any_rej && rej != '1) rej++;
    exp_pack[commit_idx] = {last_good[3], last_good[2], last_good[1], last_good[0]};
    exp_rej[commit_idx]  = rej;
    commit_idx++;
  endtask

  // Called 1 ns after an edge, returns 1 ns after the ack edge
  task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t dat);
    started = 1'b1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = dat;
    do begin
      @(posedge sys_clk);
      #1;
    end while (!wb_ack);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic set_reg(input int idx, input logic [15:0] val);
    sp[idx] = val;
    bus_access(1'b1, wb_adr_t'(idx), val);
  endtask

  task automatic commit_pass();
    model_commit();
    bus_access(1'b1, REG_COMMIT, '0);
  endtask

  task automatic read_reg(input wb_adr_t adr, input wb_dat_t expect_val);
    rd_exp = expect_val;
    bus_access(1'b0, adr, '0);
    rd_check = 1'b1;  // Ack and read data are sampled at the next edge
    @(posedge sys_clk);
    #1;
    rd_check = 1'b0;
  endtask

  task automatic wait_passes();
    wait (done_idx == commit_idx);
    @(posedge sys_clk);
    #1;
  endtask

  // Checks
  a_reset_state: assert property (@(posedge sys_clk) disable iff (!rst_n)
    !started |-> ({motor_4_rate, motor_3_rate, motor_2_rate, motor_1_rate} == '0 &&
                  reject_count == '0 && !mix_done && !wb_ack))
  else begin
    err_val++;
    $write("** Error: motor_4..1_rate = %h, reject_count = %h",
           $sampled({motor_4_rate, motor_3_rate, motor_2_rate, motor_1_rate}),
           $sampled(reject_count));
    $display(", mix_done = %h, wb_ack = %h, expected all 0",
             $sampled(mix_done), $sampled(wb_ack));
  end
  a_ack_timing: assert property (@(posedge sys_clk) disable iff (!rst_n) new_req |=> wb_ack)
  else begin
    err_tim++;
    $display("wb_ack did not follow the request by one cycle");
  end
  a_ack_single: assert property (@(posedge sys_clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
  else begin
    err_tim++;
    $display("wb_ack stayed high for more than one cycle");
  end
  a_done_latency: assert property (@(posedge sys_clk) disable iff (!rst_n)
    commit_req |-> ##4 mix_done)
  else begin
    err_tim++;
    $display("mix_done missing 4 cycles after a commit");
  end
  a_done_source: assert property (@(posedge sys_clk) disable iff (!rst_n)
    mix_done |-> $past(commit_req, 4))
  else begin
    err_tim++;
    $display("mix_done without a commit 4 cycles earlier");
  end
  a_motor_vals: assert property (@(posedge sys_clk) disable iff (!rst_n)
    mix_done |-> {motor_4_rate, motor_3_rate, motor_2_rate, motor_1_rate} == exp_pack[done_idx])
  else begin
    err_val++;
    $display("** Error: motor_4..1_rate = %h, expected %h",
             $sampled({motor_4_rate, motor_3_rate, motor_2_rate, motor_1_rate}),
             $sampled(exp_pack[done_idx]));
  end
  a_rejects: assert property (@(posedge sys_clk) disable iff (!rst_n)
    mix_done |-> reject_count == exp_rej[done_idx])
  else begin
    err_val++;
    $display("** Error: reject_count = %h, expected %h",
             $sampled(reject_count), $sampled(exp_rej[done_idx]));
  end
  a_readback: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (wb_ack && rd_check) |-> wb_dat_r == rd_exp)
  else begin
    err_val++;
    $display("** Error: wb_dat_r = %h, expected %h", $sampled(wb_dat_r), $sampled(rd_exp));
  end

  initial begin
    logic [15:0] v [4];
    rst_n = 1'b0;
    {wb_cyc, wb_stb, wb_we} = 3'b000;
    wb_adr = '0;
    wb_dat_w = '0;
    rej = '0;
    for (int m = 0; m < 4; m++) begin
      sp[m] = '0;
      last_good[m] = '0;
    end
    repeat (8) @(posedge sys_clk);
    #1 rst_n = 1'b1;
    repeat (3) @(posedge sys_clk);  // Idle outputs checked here
    #1;
    // Setpoint readback
    for (int i = 0; i < 4; i++) begin
      rand_in(-1024, 1024, v[i]);
      set_reg(i, v[i]);
    end
    for (int i = 0; i < 4; i++) read_reg(wb_adr_t'(i), v[i]);
    // Random passes, each checked at its done pulse
    for (int n = 0; n < 40; n++) begin
      for (int i = 0; i < 3; i++) begin
        rand_in(-1024, 1024, v[i]);  // +/-64.0
        set_reg(i, v[i]);
      end
      rand_in(0, 2560, v[3]);        // 0 to 160.0
      set_reg(3, v[3]);
      commit_pass();
    end
    wait_passes();
    read_reg(REG_M12, {last_good[1], last_good[0]});
    read_reg(REG_M34, {last_good[3], last_good[2]});
    // Motors 1 and 3 over the top
    set_reg(0, 16'h0000);
    set_reg(1, 16'h0200);
    set_reg(2, 16'h0000);
    set_reg(3, 16'h0E00);
    commit_pass();
    // Motors 3 and 4 below the floor
    set_reg(1, 16'h0000);
    set_reg(2, 16'hFD80);
    set_reg(3, 16'h0000);
    commit_pass();
    wait_passes();
    read_reg(REG_REJECTS, wb_dat_t'(rej));
    commit_pass();  // Two passes in flight, both rejecting
    commit_pass();
    set_reg(2, 16'h0000);
    set_reg(3, 16'h0640);
    commit_pass();
    commit_pass();
    wait_passes();
    read_reg(REG_M12, {last_good[1], last_good[0]});
    read_reg(REG_M34, {last_good[3], last_good[2]});
    read_reg(REG_REJECTS, wb_dat_t'(rej));
    repeat (4) @(posedge sys_clk);
    $display("Errors: %0d value, %0d timing", err_val, err_tim);
    if (err_val + err_tim == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- quad_mixer_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Quad X-frame motor mixer with a Wishbone classic slave
// Latency is 4 cycles from the commit sample to mix_done
// Commits may follow every 2 cycles, no back-pressure
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module quad_mixer_top import flight_pkg::*, wb_pkg::*; #(
  parameter rate_t       MOTOR_BIAS = DEF_MOTOR_BIAS,
  parameter motor_rate_t MOTOR_MIN  = DEF_MOTOR_MIN,
  parameter motor_rate_t MOTOR_MAX  = DEF_MOTOR_MAX
) (
  input  logic        sys_clk,
  input  logic        rst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  wb_adr_t     wb_adr,
  input  wb_dat_t     wb_dat_w,
  output wb_dat_t     wb_dat_r,
  output logic        wb_ack,
  output motor_rate_t motor_1_rate,
  output motor_rate_t motor_2_rate,
  output motor_rate_t motor_3_rate,
  output motor_rate_t motor_4_rate,
  output logic        mix_done,
  output reject_cnt_t reject_count
);

  rate_t       yaw;
  rate_t       roll;
  rate_t       pitch;
  rate_t       throttle;
  logic        commit;
  motor_rate_t ch_rate [4];
  logic [3:0]  ch_rejected;
  logic [3:0]  ch_valid;
  motor_rate_t motor_rate [4];  // Bank outputs, index 0 is motor 1

  mixer_if mix_bus [4] ();

  wb_rate_regs u_regs (
    .sys_clk(sys_clk), .rst_n(rst_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .motor_rate(motor_rate), .reject_count(reject_count),
    .yaw(yaw), .roll(roll), .pitch(pitch), .throttle(throttle), .commit(commit)
  );

  mix_sign_distributor u_dist (
    .sys_clk(sys_clk), .rst_n(rst_n), .commit(commit),
    .yaw(yaw), .roll(roll), .pitch(pitch), .throttle(throttle), .ch(mix_bus)
  );

  for (genvar m = 0; m < 4; m++) begin : g_chan
    motor_rate_channel #(
      .MOTOR_BIAS(MOTOR_BIAS), .MOTOR_MIN(MOTOR_MIN), .MOTOR_MAX(MOTOR_MAX)
    ) u_chan (
      .sys_clk(sys_clk), .rst_n(rst_n), .term(mix_bus[m]),
      .rate(ch_rate[m]), .rejected(ch_rejected[m]), .rate_valid(ch_valid[m])
    );
  end

  motor_output_bank u_bank (
    .sys_clk(sys_clk), .rst_n(rst_n),
    .rate(ch_rate), .rejected(ch_rejected), .rate_valid(ch_valid),
    .motor_rate(motor_rate), .done(mix_done), .reject_count(reject_count)
  );

  assign motor_1_rate = motor_rate[0];
  assign motor_2_rate = motor_rate[1];
  assign motor_3_rate = motor_rate[2];
  assign motor_4_rate = motor_rate[3];

endmodule

//--- motor_output_bank.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Latches all four motor rates in one edge and pulses done
// Channels present their held value on rejection, so all four load
// reject_count saturates at all ones
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module motor_output_bank import flight_pkg::*; (
  input  logic        sys_clk,
  input  logic        rst_n,
  input  motor_rate_t rate [4],
  input  logic [3:0]  rejected,
  input  logic [3:0]  rate_valid,
  output motor_rate_t motor_rate [4],
  output logic        done,
  output reject_cnt_t reject_count
);

  logic pass_valid;
  logic pass_rejected;  // At least one motor held back

  assign pass_valid    = &rate_valid;
  assign pass_rejected = pass_valid && (|rejected);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++) begin
        motor_rate[i] <= '0;
      end
      done         <= 1'b0;
      reject_count <= '0;
    end else begin
      done <= pass_valid;
      if (pass_valid) begin
        for (int i = 0; i < 4; i++) begin
          motor_rate[i] <= rate[i];  // All motors move together
        end
      end
      if (pass_rejected && (reject_count != '1)) begin
        reject_count <= reject_count + 1'b1;  // One count per pass
      end
    end
  end

  // Channels run in lockstep
  a_valid_lockstep: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    (rate_valid == 4'b0000) || (rate_valid == 4'b1111)
  ) else $error("Channel rate_valid bits differ: %b", rate_valid);

endmodule

//--- motor_rate_channel.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One motor: bias + throttle + half of each signed term
// Rounds half up to an integer rate, one cycle after valid
// Out of range results are dropped, the last good rate is held
// MOTOR_MIN must not exceed MOTOR_MAX
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module motor_rate_channel import flight_pkg::*; #(
  parameter rate_t       MOTOR_BIAS = DEF_MOTOR_BIAS,
  parameter motor_rate_t MOTOR_MIN  = DEF_MOTOR_MIN,
  parameter motor_rate_t MOTOR_MAX  = DEF_MOTOR_MAX
) (
  input  logic        sys_clk,
  input  logic        rst_n,
  mixer_if.snk        term,
  output motor_rate_t rate,
  output logic        rejected,
  output logic        rate_valid
);

  mix_sum_t sum;      // Q.4 accumulator
  mix_sum_t rounded;  // Integer part after rounding
  logic     in_range;

  if (MOTOR_MIN > MOTOR_MAX) begin : g_bad_limits
    $error("MOTOR_MIN above MOTOR_MAX");
  end

  // Arithmetic shifts keep the sign of each half term
  assign sum = mix_sum_t'(MOTOR_BIAS)
             + mix_sum_t'(term.throttle)
             + mix_sum_t'(term.yaw_term >>> 1)
             + mix_sum_t'(term.pitch_term >>> 1)
             + mix_sum_t'(term.roll_term >>> 1);

  assign rounded  = (sum + ROUND_HALF) >>> RATE_FRAC_W;
  // Negative sums fail here before any truncation
  assign in_range = (rounded >= mix_sum_t'(MOTOR_MIN)) &&
                    (rounded <= mix_sum_t'(MOTOR_MAX));

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rate_valid <= 1'b0;
      rejected   <= 1'b0;
      rate       <= '0;  // Last good value
    end else begin
      rate_valid <= term.valid;
      if (term.valid) begin
        rejected <= !in_range;
        if (in_range) begin
          rate <= motor_rate_t'(rounded);  // Fits, checked above
        end
      end
    end
  end

  // Rate leaving the channel as accepted is always inside the limits
  a_rate_in_limits: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    (rate_valid && !rejected) |-> (rate >= MOTOR_MIN && rate <= MOTOR_MAX)
  ) else $error("Accepted rate %0d outside %0d..%0d", rate, MOTOR_MIN, MOTOR_MAX);

endmodule

//--- mix_sign_distributor.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Applies the quad X-frame sign table to the committed setpoints
// Loads all four motor buses one cycle after commit
// Negating -32768 wraps, callers keep commands inside range
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mix_sign_distributor import flight_pkg::*; (
  input  logic  sys_clk,
  input  logic  rst_n,
  input  logic  commit,
  input  rate_t yaw,
  input  rate_t roll,
  input  rate_t pitch,
  input  rate_t throttle,
  mixer_if.src  ch [4]
);

  // Bit m set means motor m+1 takes the negated command
  localparam logic [3:0] YAW_NEG   = 4'b1001;  // Motors 1 and 4
  localparam logic [3:0] ROLL_NEG  = 4'b1010;  // Motors 2 and 4
  localparam logic [3:0] PITCH_NEG = 4'b0011;  // Motors 1 and 2

  rate_t yaw_n;
  rate_t roll_n;
  rate_t pitch_n;

  // Shared negations, one per command
  assign yaw_n   = -yaw;
  assign roll_n  = -roll;
  assign pitch_n = -pitch;

  for (genvar m = 0; m < 4; m++) begin : g_motor
    always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
        ch[m].valid <= 1'b0;
      end else begin
        ch[m].valid <= commit;
      end
    end

    // Terms only move on commit, a second pass may follow two cycles later
    always_ff @(posedge sys_clk) begin
      if (commit) begin
        ch[m].yaw_term   <= YAW_NEG[m]   ? yaw_n   : yaw;
        ch[m].roll_term  <= ROLL_NEG[m]  ? roll_n  : roll;
        ch[m].pitch_term <= PITCH_NEG[m] ? pitch_n : pitch;
        ch[m].throttle   <= throttle;  // No sign on throttle
      end
    end

    a_valid_after_commit: assert property (
      @(posedge sys_clk) disable iff (!rst_n)
      ch[m].valid == $past(commit)
    ) else $error("Motor %0d valid out of step with commit", m + 1);
  end

endmodule

//--- wb_rate_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave for the mixer setpoints
// Every access acks one cycle after it is sampled, ack lasts one cycle
// Master must hold the request until ack
// Setpoints and commit update at the edge that raises ack
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module wb_rate_regs import flight_pkg::*, wb_pkg::*; (
  input  logic        sys_clk,
  input  logic        rst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  wb_adr_t     wb_adr,
  input  wb_dat_t     wb_dat_w,
  output wb_dat_t     wb_dat_r,
  output logic        wb_ack,
  input  motor_rate_t motor_rate [4],
  input  reject_cnt_t reject_count,
  output rate_t       yaw,
  output rate_t       roll,
  output rate_t       pitch,
  output rate_t       throttle,
  output logic        commit
);

  wb_reg_e reg_sel;
  logic    req;      // New request this cycle
  logic    wr_req;
  wb_dat_t rd_data;

  assign reg_sel = wb_reg_e'(wb_adr);
  // Request still high during ack is the tail of the same access
  assign req     = wb_cyc && wb_stb && !wb_ack;
  assign wr_req  = req && wb_we;

  // Readback mux
  always_comb begin
    case (reg_sel)
      REG_YAW:      rd_data = wb_dat_t'(yaw);
      REG_ROLL:     rd_data = wb_dat_t'(roll);
      REG_PITCH:    rd_data = wb_dat_t'(pitch);
      REG_THROTTLE: rd_data = wb_dat_t'(throttle);
      REG_M12:      rd_data = {motor_rate[1], motor_rate[0]};  // Motor 2 high
      REG_M34:      rd_data = {motor_rate[3], motor_rate[2]};  // Motor 4 high
      REG_REJECTS:  rd_data = wb_dat_t'(reject_count);
      default:      rd_data = '0;  // Commit reads as zero
    endcase
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack   <= 1'b0;
      commit   <= 1'b0;
      wb_dat_r <= '0;
      yaw      <= '0;
      roll     <= '0;
      pitch    <= '0;
      throttle <= '0;
    end else begin
      wb_ack <= req;
      commit <= wr_req && (reg_sel == REG_COMMIT);  // One pulse per write
      if (req && !wb_we) begin
        wb_dat_r <= rd_data;  // Held until the next read
      end
      if (wr_req) begin
        case (reg_sel)
          REG_YAW:      yaw      <= rate_t'(wb_dat_w);
          REG_ROLL:     roll     <= rate_t'(wb_dat_w);
          REG_PITCH:    pitch    <= rate_t'(wb_dat_w);
          REG_THROTTLE: throttle <= rate_t'(wb_dat_w);
          default:      ;  // Strobe and read-only registers
        endcase
      end
    end
  end

  // Ack only answers a request seen at the previous edge
  a_ack_follows_req: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    wb_ack |-> $past(wb_cyc && wb_stb)
  ) else $error("wb_ack without a request in the previous cycle");

endmodule

//--- mixer_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One motor's signed terms, distributor to channel
// Terms already carry the X-frame sign, not yet halved
// valid is a single-cycle pulse, there is no ready
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface mixer_if import flight_pkg::*;;

  rate_t yaw_term;    // +/- yaw for this motor
  rate_t roll_term;   // +/- roll
  rate_t pitch_term;  // +/- pitch
  rate_t throttle;    // Shared by all motors
  logic  valid;       // Terms are new this cycle

  modport src (
    output yaw_term,
    output roll_term,
    output pitch_term,
    output throttle,
    output valid
  );

  modport snk (
    input yaw_term,
    input roll_term,
    input pitch_term,
    input throttle,
    input valid
  );

endinterface

//--- wb_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic types and register map
// Word addressed, 16-bit data, no byte selects
// Motor pair registers put the higher motor in the high byte
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package wb_pkg;

  typedef logic [2:0]  wb_adr_t;  // Word address
  typedef logic [15:0] wb_dat_t;

  // Register map
  typedef enum logic [2:0] {
    REG_YAW      = 3'd0,  // Q12.4 setpoints, read and write
    REG_ROLL     = 3'd1,
    REG_PITCH    = 3'd2,
    REG_THROTTLE = 3'd3,
    REG_COMMIT   = 3'd4,  // Write starts a pass, reads 0
    REG_M12      = 3'd5,  // {motor 2, motor 1}
    REG_M34      = 3'd6,  // {motor 4, motor 3}
    REG_REJECTS  = 3'd7   // Rejected pass count
  } wb_reg_e;

endpackage

//--- flight_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-point types for the motor mixer
// Rate commands are Q12.4 two's complement
// mix_sum_t is two bits wider than rate_t so that five terms cannot overflow
// The motor limits and bias here are only defaults for the top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package flight_pkg;

  localparam int RATE_W       = 16;
  localparam int RATE_FRAC_W  = 4;           // Fraction bits of Q12.4
  localparam int MIX_SUM_W    = RATE_W + 2;  // Bias, throttle and three half terms
  localparam int MOTOR_RATE_W = 8;
  localparam int REJECT_CNT_W = 16;

  // Signed Q12.4 rate command
  typedef logic signed [RATE_W-1:0]    rate_t;
  // Channel accumulator, same fraction position as rate_t
  typedef logic signed [MIX_SUM_W-1:0] mix_sum_t;
  typedef logic [MOTOR_RATE_W-1:0]     motor_rate_t;  // Integer motor rate
  typedef logic [REJECT_CNT_W-1:0]     reject_cnt_t;  // Saturating pass counter

  // Half an LSB of the integer part, added before truncating the fraction
  localparam mix_sum_t ROUND_HALF = mix_sum_t'(1 << (RATE_FRAC_W - 1));

  // Idle bias of 20.0 in Q12.4
  localparam rate_t       DEF_MOTOR_BIAS = 16'h0140;
  localparam motor_rate_t DEF_MOTOR_MIN  = 8'd16;   // Lowest rate still spinning
  localparam motor_rate_t DEF_MOTOR_MAX  = 8'd240;  // Headroom below full scale

endpackage
